//--- Bender.yml
package:
  name: hsv_video

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/hsv_pkg.sv
      - rtl/hsv_divider.sv
      - rtl/rgb2hsv_core.sv
      - rtl/hsv_ctrl_regs.sv
      - rtl/hsv_video_top.sv
  - target: test
    include_dirs:
      - rtl
      - tests
    files:
      - tests/hsv_tb.sv

//--- project.f
+incdir+rtl
+incdir+tests
rtl/hsv_pkg.sv
rtl/hsv_divider.sv
rtl/rgb2hsv_core.sv
rtl/hsv_ctrl_regs.sv
rtl/hsv_video_top.sv
tests/hsv_tb.sv

//--- rtl/hsv_ctrl_regs.sv
/*
 * Wishbone-style register block. Holds the bypass control bit and a
 * counter of accepted frame starts. Single-cycle ack, one cycle after strobe.
 */
`include "hsv_defs.svh"

module hsv_ctrl_regs
    import hsv_pkg::*;
(
    input  logic                     aclk,
    input  logic                     reset_i,
    input  logic [`HSV_WB_ADR_W-1:0] wb_adr_i,
    input  logic [`HSV_WB_DAT_W-1:0] wb_dat_i,
    output logic [`HSV_WB_DAT_W-1:0] wb_dat_o,
    input  logic                     wb_we_i,
    input  logic                     wb_stb_i,
    output logic                     wb_ack_o,
    input  logic                     sof_accepted_i,
    output logic                     bypass_o
);

    reg_addr_e                 adr;
    logic                      access;
    logic                      ack_q;
    logic                      bypass_q;
    logic [`HSV_WB_DAT_W-1:0]  frames_q;
    logic [`HSV_WB_DAT_W-1:0]  rdata_q;

    assign adr    = reg_addr_e'(wb_adr_i);
    assign access = wb_stb_i && !ack_q;  // new strobe, no ack pending.

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            ack_q    <= 1'b0;
            bypass_q <= 1'b0;
            frames_q <= '0;
        end else begin
            ack_q <= access;
            if (access && wb_we_i && adr == REG_FRAMES) begin
                frames_q <= '0;                  // clear wins over a new frame.
            end else if (sof_accepted_i) begin
                frames_q <= frames_q + 1'b1;
            end
            if (access && wb_we_i && adr == REG_CTRL) begin
                bypass_q <= wb_dat_i[0];
            end
        end
    end

    // read data is captured with the ack.
    always_ff @(posedge aclk) begin
        if (access) begin
            case (adr)
                REG_CTRL:   rdata_q <= `HSV_WB_DAT_W'(bypass_q);
                REG_FRAMES: rdata_q <= frames_q;
                default:    rdata_q <= '0;
            endcase
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = rdata_q;
    assign bypass_o = bypass_q;

    a_ack_single: assert property (@(posedge aclk) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

//--- rtl/hsv_defs.svh
/*
 * Widths, scale factors, register addresses and pipeline depth shared by
 * the converter RTL and its testbench. Include wherever a macro is needed.
 */
`ifndef HSV_DEFS_SVH
`define HSV_DEFS_SVH

`define HSV_DATA_W      10                      // bits per colour component.
`define HSV_MAX_VAL     1023                    // full-scale component value.
`define HSV_HUE_SECTOR  170                     // hue steps in 60 degrees.
`define HSV_DIV_STAGES  `HSV_DATA_W             // one stage per quotient bit.
`define HSV_LATENCY     (`HSV_DIV_STAGES + 2)   // input stage + output stage.

`define HSV_WB_ADR_W    8
`define HSV_WB_DAT_W    32
`define HSV_REG_CTRL    0                       // bit 0 selects bypass.
`define HSV_REG_FRAMES  1                       // accepted frame starts.

`endif

//--- rtl/hsv_divider.sv
/*
 * Pipelined restoring divider, one quotient bit settled per register stage.
 * The quotient follows its operands by WIDTH enabled clocks. It is only
 * meaningful for a non-zero divisor and a quotient that fits WIDTH bits.
 */
`include "hsv_defs.svh"

module hsv_divider #(
    parameter int WIDTH = `HSV_DATA_W
) (
    input  logic               aclk,
    input  logic               reset_i,
    input  logic               enable_i,
    input  logic [2*WIDTH-1:0] dividend_i,
    input  logic [WIDTH-1:0]   divisor_i,
    output logic [WIDTH-1:0]   quotient_o
);

    localparam int DW = 2 * WIDTH;

    logic [DW-1:0]    rem_q  [WIDTH-1];  // partial remainder.
    logic [WIDTH-1:0] dsr_q  [WIDTH-1];  // divisor riding along.
    logic [WIDTH-1:0] quot_q [WIDTH];    // quotient bits so far.

    for (genvar k = 0; k < WIDTH; k++) begin : g_stage
        localparam int BIT = WIDTH - 1 - k;  // quotient bit decided here.

        logic [DW-1:0]    rem_in;
        logic [WIDTH-1:0] dsr_in;
        logic [WIDTH-1:0] quot_in;
        logic [DW-1:0]    shifted;
        logic             take;

        if (k == 0) begin : g_head
            assign rem_in  = dividend_i;
            assign dsr_in  = divisor_i;
            assign quot_in = '0;
        end else begin : g_body
            assign rem_in  = rem_q[k-1];
            assign dsr_in  = dsr_q[k-1];
            assign quot_in = quot_q[k-1];
        end

        // trial subtraction of the divisor aligned to this bit.
        assign shifted = DW'(dsr_in) << BIT;
        assign take    = rem_in >= shifted;

        always_ff @(posedge aclk) begin
            if (reset_i) begin
                quot_q[k] <= '0;
            end else if (enable_i) begin
                quot_q[k] <= quot_in | (WIDTH'(take) << BIT);
            end
        end

        // the last stage has no successor, so no remainder to pass on.
        if (k < WIDTH - 1) begin : g_pass
            always_ff @(posedge aclk) begin
                if (enable_i) begin
                    rem_q[k] <= take ? rem_in - shifted : rem_in;  // restore on fail.
                    dsr_q[k] <= dsr_in;
                end
            end
        end
    end

    assign quotient_o = quot_q[WIDTH-1];

endmodule

//--- rtl/hsv_pkg.sv
/*
 * Pixel and stream beat structs, plus the enums for hue sectors and
 * register addresses. Import into modules that use the types.
 */
`include "hsv_defs.svh"

package hsv_pkg;

    // input pixel, r in the top bits.
    typedef struct packed {
        logic [`HSV_DATA_W-1:0] r;
        logic [`HSV_DATA_W-1:0] g;
        logic [`HSV_DATA_W-1:0] b;
    } rgb_pixel_t;

    typedef struct packed {
        logic [`HSV_DATA_W-1:0] h;
        logic [`HSV_DATA_W-1:0] s;
        logic [`HSV_DATA_W-1:0] v;
    } hsv_pixel_t;

    // one stream beat, data holds either an rgb or an hsv word.
    typedef struct packed {
        logic                     tuser;  // frame start.
        logic                     tlast;  // line end.
        logic [3*`HSV_DATA_W-1:0] data;
    } video_beat_t;

    // 60 degree sectors in hue order, value times sector size is the base hue.
    typedef enum logic [2:0] {
        SEC_RY = 3'd0,
        SEC_YG = 3'd1,
        SEC_GC = 3'd2,
        SEC_CB = 3'd3,
        SEC_BM = 3'd4,
        SEC_MR = 3'd5
    } hue_sector_e;

    typedef enum logic [`HSV_WB_ADR_W-1:0] {
        REG_CTRL   = `HSV_WB_ADR_W'(`HSV_REG_CTRL),
        REG_FRAMES = `HSV_WB_ADR_W'(`HSV_REG_FRAMES)
    } reg_addr_e;

endpackage

//--- rtl/hsv_video_top.sv
/*
 * Top level of the colour-space converter. Joins the stream pipeline
 * with the register block that supplies bypass and counts frame starts.
 */
`include "hsv_defs.svh"

module hsv_video_top
    import hsv_pkg::*;
(
    input  logic                     aclk,
    input  logic                     reset_i,

    // pixel stream in.
    input  video_beat_t              s_beat_i,
    input  logic                     s_valid_i,
    output logic                     s_ready_o,

    // pixel stream out.
    output video_beat_t              m_beat_o,
    output logic                     m_valid_o,
    input  logic                     m_ready_i,

    // register bus.
    input  logic [`HSV_WB_ADR_W-1:0] wb_adr_i,
    input  logic [`HSV_WB_DAT_W-1:0] wb_dat_i,
    output logic [`HSV_WB_DAT_W-1:0] wb_dat_o,
    input  logic                     wb_we_i,
    input  logic                     wb_stb_i,
    output logic                     wb_ack_o
);

    logic bypass;
    logic sof_accepted;  // frame start taken by the core.

    rgb2hsv_core u_core (
        .aclk           (aclk),
        .reset_i        (reset_i),
        .s_beat_i       (s_beat_i),
        .s_valid_i      (s_valid_i),
        .s_ready_o      (s_ready_o),
        .m_beat_o       (m_beat_o),
        .m_valid_o      (m_valid_o),
        .m_ready_i      (m_ready_i),
        .bypass_i       (bypass),
        .sof_accepted_o (sof_accepted)
    );

    hsv_ctrl_regs u_regs (
        .aclk           (aclk),
        .reset_i        (reset_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_we_i        (wb_we_i),
        .wb_stb_i       (wb_stb_i),
        .wb_ack_o       (wb_ack_o),
        .sof_accepted_i (sof_accepted),
        .bypass_o       (bypass)
    );

endmodule

//--- rtl/rgb2hsv_core.sv
/*
 * RGB to HSV conversion pipeline for a valid/ready pixel stream.
 * Input stage, two dividers side by side, output stage. The whole pipe moves
 * only on advance, so back-pressure freezes every beat in place.
 */
`include "hsv_defs.svh"

module rgb2hsv_core
    import hsv_pkg::*;
(
    input  logic        aclk,
    input  logic        reset_i,
    input  video_beat_t s_beat_i,
    input  logic        s_valid_i,
    output logic        s_ready_o,
    output video_beat_t m_beat_o,
    output logic        m_valid_o,
    input  logic        m_ready_i,
    input  logic        bypass_i,
    output logic        sof_accepted_o
);

    localparam int W      = `HSV_DATA_W;
    localparam int DW     = 2 * W;
    localparam int STAGES = `HSV_DIV_STAGES;

    // per-beat data that waits beside the dividers.
    typedef struct packed {
        logic        tuser;
        logic        tlast;
        logic        bypass;  // sampled on entry.
        rgb_pixel_t  rgb;
        hue_sector_e sector;
        logic [W-1:0] vmax;
        logic        gray;    // delta is zero.
        logic        black;   // max is zero.
    } side_t;

    logic        advance;
    rgb_pixel_t  in_px;
    logic        red_max;
    logic        grn_max;
    logic [W-1:0] vmax;
    logic [W-1:0] vmin;
    logic [W-1:0] delta;
    logic [W-1:0] hue_num;
    hue_sector_e sector;

    logic        s1_valid_q;
    side_t       s1_side_q;
    logic [W-1:0] s1_delta_q;
    logic [W-1:0] s1_num_q;

    logic [STAGES-1:0] dly_valid_q;
    side_t             dly_side_q [STAGES];

    logic [W-1:0] sat_quot;
    logic [W-1:0] hue_quot;
    side_t        last;
    hsv_pixel_t   hsv;
    logic         out_valid_q;
    video_beat_t  out_beat_q;

    assign advance        = !out_valid_q || m_ready_i;
    assign s_ready_o      = advance;
    assign sof_accepted_o = s_valid_i && advance && s_beat_i.tuser;

    ////////////////////////////////////////
    // stage 1: extremes, sector, numerator.
    ////////////////////////////////////////

    assign in_px = rgb_pixel_t'(s_beat_i.data);

    always_comb begin
        red_max = (in_px.r >= in_px.g) && (in_px.r >= in_px.b);  // ties go red.
        grn_max = !red_max && (in_px.g >= in_px.b);              // then green.
        vmax    = red_max ? in_px.r : (grn_max ? in_px.g : in_px.b);
        vmin    = (in_px.r <= in_px.g && in_px.r <= in_px.b) ? in_px.r :
                  ((in_px.g <= in_px.b) ? in_px.g : in_px.b);
        delta   = vmax - vmin;
        if (red_max) begin
            if (in_px.g >= in_px.b) begin
                sector  = SEC_RY;
                hue_num = in_px.g - in_px.b;
            end else begin
                sector  = SEC_MR;
                hue_num = delta - (in_px.b - in_px.g);
            end
        end else if (grn_max) begin
            if (in_px.r > in_px.b) begin
                sector  = SEC_YG;
                hue_num = delta - (in_px.r - in_px.b);
            end else begin
                sector  = SEC_GC;
                hue_num = in_px.b - in_px.r;
            end
        end else begin
            if (in_px.g >= in_px.r) begin
                sector  = SEC_CB;
                hue_num = delta - (in_px.g - in_px.r);
            end else begin
                sector  = SEC_BM;
                hue_num = in_px.r - in_px.g;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            s1_valid_q <= 1'b0;
        end else if (advance) begin
            s1_valid_q <= s_valid_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (advance) begin
            s1_side_q.tuser  <= s_beat_i.tuser;
            s1_side_q.tlast  <= s_beat_i.tlast;
            s1_side_q.bypass <= bypass_i;
            s1_side_q.rgb    <= in_px;
            s1_side_q.sector <= sector;
            s1_side_q.vmax   <= vmax;
            s1_side_q.gray   <= (delta == '0);
            s1_side_q.black  <= (vmax == '0);
            s1_delta_q       <= delta;
            s1_num_q         <= hue_num;
        end
    end

    ////////////////////////////////////////
    // dividers and matching delay line.
    ////////////////////////////////////////

    hsv_divider #(.WIDTH(W)) u_sat_div (
        .aclk       (aclk),
        .reset_i    (reset_i),
        .enable_i   (advance),
        .dividend_i (DW'(s1_delta_q) * DW'(`HSV_MAX_VAL)),
        .divisor_i  (s1_side_q.vmax),
        .quotient_o (sat_quot)
    );

    hsv_divider #(.WIDTH(W)) u_hue_div (
        .aclk       (aclk),
        .reset_i    (reset_i),
        .enable_i   (advance),
        .dividend_i (DW'(s1_num_q) * DW'(`HSV_HUE_SECTOR)),
        .divisor_i  (s1_delta_q),
        .quotient_o (hue_quot)
    );

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            dly_valid_q <= '0;
        end else if (advance) begin
            dly_valid_q <= {dly_valid_q[STAGES-2:0], s1_valid_q};
        end
    end

    always_ff @(posedge aclk) begin
        if (advance) begin
            dly_side_q[0] <= s1_side_q;
            for (int i = 1; i < STAGES; i++) begin
                dly_side_q[i] <= dly_side_q[i-1];
            end
        end
    end

    ////////////////////////////////////////
    // output stage.
    ////////////////////////////////////////

    assign last = dly_side_q[STAGES-1];

    always_comb begin
        hsv.v = last.vmax;
        hsv.s = last.black ? '0 : sat_quot;  // divisor was zero.
        hsv.h = last.gray ? '0 : W'(last.sector) * W'(`HSV_HUE_SECTOR) + hue_quot;
    end

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            out_valid_q <= 1'b0;
        end else if (advance) begin
            out_valid_q <= dly_valid_q[STAGES-1];
        end
    end

    always_ff @(posedge aclk) begin
        if (advance) begin
            out_beat_q.tuser <= last.tuser;
            out_beat_q.tlast <= last.tlast;
            out_beat_q.data  <= last.bypass ? last.rgb : hsv;
        end
    end

    assign m_valid_o = out_valid_q;
    assign m_beat_o  = out_beat_q;

    // a stalled beat stays offered and unchanged.
    a_valid_hold: assert property (@(posedge aclk) disable iff (reset_i)
        m_valid_o && !m_ready_i |=> m_valid_o);
    a_beat_stable: assert property (@(posedge aclk) disable iff (reset_i)
        m_valid_o && !m_ready_i |=> $stable(m_beat_o));
    a_reset_idle: assert property (@(posedge aclk) reset_i |=> !m_valid_o);

endmodule

//--- tests/hsv_tb_model.svh
/*
 * Reference HSV rule and bypass selection for the converter testbench.
 * Include inside the testbench module, after the package import.
 */
`ifndef HSV_TB_MODEL_SVH
`define HSV_TB_MODEL_SVH

// hsv of one pixel, straight from the sector table, rounding down.
function automatic hsv_pixel_t hsv_of_rgb(input rgb_pixel_t px);
    int          r;
    int          g;
    int          b;
    int          mx;
    int          mn;
    int          d;
    int          num;
    int          h;
    int          s;
    hue_sector_e sec;
    hsv_pixel_t  res;
    r  = int'(px.r);
    g  = int'(px.g);
    b  = int'(px.b);
    mx = (r > g) ? r : g;
    mx = (b > mx) ? b : mx;
    mn = (r < g) ? r : g;
    mn = (b < mn) ? b : mn;
    d  = mx - mn;
    if (r == mx) begin              // red wins every tie.
        sec = (g >= b) ? SEC_RY : SEC_MR;
        num = (g >= b) ? g - b : d - (b - g);
    end else if (g == mx) begin
        sec = (r > b) ? SEC_YG : SEC_GC;
        num = (r > b) ? d - (r - b) : b - r;
    end else begin
        sec = (g >= r) ? SEC_CB : SEC_BM;
        num = (g >= r) ? d - (g - r) : r - g;
    end
    s = (mx == 0) ? 0 : d * `HSV_MAX_VAL / mx;
    h = (d == 0) ? 0 : int'(sec) * `HSV_HUE_SECTOR + num * `HSV_HUE_SECTOR / d;
    res.h = `HSV_DATA_W'(h);
    res.s = `HSV_DATA_W'(s);
    res.v = `HSV_DATA_W'(mx);
    return res;
endfunction

// the beat expected at the output for a given input beat.
function automatic video_beat_t expected_beat(input video_beat_t beat, input logic bypass);
    video_beat_t res;
    res = beat;
    if (!bypass) begin
        res.data = hsv_of_rgb(rgb_pixel_t'(beat.data));
    end
    return res;
endfunction

`endif

//--- tests/hsv_tb.sv
/*
 * Testbench for the HSV video converter. Streams gray, random and
 * back-pressured pixels, toggles bypass and reads the frame counter
 * over the register bus. Concurrent assertions check every response.
 */
`include "hsv_defs.svh"

module hsv_tb
    import hsv_pkg::*;
();

    localparam int N_GRAY   = 4;
    localparam int N_RANDOM = 48;
    localparam int N_STALL  = 48;
    localparam int N_BYPASS = 8;     // per bypass setting.
    localparam int N_BUS    = 5;
    localparam int N_BEATS  = N_GRAY + N_RANDOM + N_STALL + 2 * N_BYPASS;
    localparam int LIMIT    = 2 * (N_BEATS + N_BUS) + `HSV_LATENCY + 100;

    typedef struct packed {
        video_beat_t beat;
        logic [31:0] adv;            // advance count at acceptance.
    } expect_t;

    logic                     aclk = 1'b0;
    logic                     reset_i;
    video_beat_t              s_beat_i;
    logic                     s_valid_i;
    logic                     s_ready_o;
    video_beat_t              m_beat_o;
    logic                     m_valid_o;
    logic                     m_ready_i;
    logic [`HSV_WB_ADR_W-1:0] wb_adr_i;
    logic [`HSV_WB_DAT_W-1:0] wb_dat_i;
    logic [`HSV_WB_DAT_W-1:0] wb_dat_o;
    logic                     wb_we_i;
    logic                     wb_stb_i;
    logic                     wb_ack_o;

    integer      seed = 55602;
    int unsigned cycle_cnt = 0;
    int unsigned beat_idx = 0;
    int unsigned sof_total;
    int unsigned sof_at_clear;
    logic [31:0] adv_cnt;
    logic [31:0] rd_expect;
    logic        rd_check;
    logic        bypass_mode;
    logic        stall_on;
    logic        in_fire;
    logic        out_fire;
    logic        head_valid;
    expect_t     head;
    expect_t     exp_q[$];

    `include "hsv_tb_model.svh"

    hsv_video_top dut0 (.*);

    always #2 aclk = ~aclk;

    assign in_fire  = s_valid_i && s_ready_o;
    assign out_fire = m_valid_o && m_ready_i;

    ////////////////////////////////////////
    // scoreboard and advance counter.
    ////////////////////////////////////////

    always @(posedge aclk) begin
        if (reset_i) begin
            adv_cnt    <= '0;
            sof_total  <= 0;
            head_valid <= 1'b0;
        end else begin
            if (!m_valid_o || m_ready_i) begin
                adv_cnt <= adv_cnt + 1;   // pipeline moves this edge.
            end
            if (out_fire && exp_q.size() != 0) begin
                exp_q.delete(0);
            end
            if (in_fire) begin
                exp_q.push_back(expect_t'({expected_beat(s_beat_i, bypass_mode), adv_cnt}));
                if (s_beat_i.tuser) begin
                    sof_total <= sof_total + 1;
                end
            end
            head_valid <= (exp_q.size() != 0);
            if (exp_q.size() != 0) begin
                head <= exp_q[0];
            end
        end
    end

    task automatic report_error(input string msg);
        $display("error %0t: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    a_idle_after_reset: assert property (@(posedge aclk)
        $fell(reset_i) |-> !m_valid_o && !wb_ack_o && s_ready_o)
        else report_error("output valid, bus ack or input ready wrong right after reset");
    a_beat_match: assert property (@(posedge aclk) disable iff (reset_i)
        out_fire |-> head_valid && m_beat_o == head.beat)
        else report_error($sformatf("beat %h, expected %h",
                                    $sampled(m_beat_o), $sampled(head.beat)));
    a_latency: assert property (@(posedge aclk) disable iff (reset_i)
        out_fire |-> adv_cnt == head.adv + `HSV_LATENCY)
        else report_error("beat left after the wrong number of advances");
    a_ack_after_strobe: assert property (@(posedge aclk) disable iff (reset_i)
        $rose(wb_stb_i) |=> wb_ack_o)
        else report_error("no ack one cycle after strobe");
    a_ack_once: assert property (@(posedge aclk) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o)
        else report_error("ack held for more than one cycle");
    a_read_value: assert property (@(posedge aclk) disable iff (reset_i)
        wb_ack_o && rd_check |-> wb_dat_o == rd_expect)
        else report_error($sformatf("read %0d, expected %0d",
                                    $sampled(wb_dat_o), $sampled(rd_expect)));

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    ////////////////////////////////////////
    // stimulus.
    ////////////////////////////////////////

    function automatic rgb_pixel_t random_pixel();
        logic [31:0] rnd;
        rnd = $random(seed);
        return rgb_pixel_t'(rnd[3*`HSV_DATA_W-1:0]);
    endfunction

    // offers one beat until it is taken; frame start every 8, line end every 4.
    task automatic send_rgb(input rgb_pixel_t px);
        logic [31:0] rnd;
        logic        taken;
        s_beat_i.tuser = (beat_idx % 8 == 0);
        s_beat_i.tlast = (beat_idx % 4 == 3);
        s_beat_i.data  = px;
        s_valid_i      = 1'b1;
        taken          = 1'b0;
        while (!taken) begin
            rnd       = $random(seed);
            m_ready_i = stall_on ? (rnd[1:0] != 2'b00) : 1'b1;
            #1;
            taken = s_ready_o;
            @(posedge aclk);
            #1;
        end
        s_valid_i = 1'b0;
        beat_idx++;
    endtask

    task automatic bus_access(input reg_addr_e adr, input logic we, input logic [31:0] wdata);
        wb_adr_i = adr;
        wb_we_i  = we;
        wb_dat_i = wdata;
        wb_stb_i = 1'b1;
        do begin
            @(posedge aclk);
            #1;
        end while (!wb_ack_o);
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(posedge aclk);             // ack edge.
        #1;
    endtask

    task automatic check_frames();
        rd_expect = sof_total - sof_at_clear;
        rd_check  = 1'b1;
        bus_access(REG_FRAMES, 1'b0, '0);
        rd_check  = 1'b0;
    endtask

    initial begin
        reset_i      = 1'b1;
        s_beat_i     = '0;
        s_valid_i    = 1'b0;
        m_ready_i    = 1'b1;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        wb_we_i      = 1'b0;
        wb_stb_i     = 1'b0;
        rd_check     = 1'b0;
        rd_expect    = '0;
        bypass_mode  = 1'b0;
        stall_on     = 1'b0;
        sof_at_clear = 0;
        repeat (2) @(posedge aclk);
        #1;
        reset_i = 1'b0;
        @(posedge aclk);             // one idle cycle before input.
        #1;

        send_rgb({3{`HSV_DATA_W'(0)}});
        send_rgb({3{`HSV_DATA_W'(`HSV_MAX_VAL)}});
        send_rgb({3{`HSV_DATA_W'(512)}});
        send_rgb({3{`HSV_DATA_W'(37)}});
        repeat (N_RANDOM) send_rgb(random_pixel());

        stall_on = 1'b1;             // random back-pressure.
        repeat (N_STALL) send_rgb(random_pixel());
        stall_on  = 1'b0;
        m_ready_i = 1'b1;

        bus_access(REG_CTRL, 1'b1, 32'd1);
        bypass_mode = 1'b1;
        repeat (N_BYPASS) send_rgb(random_pixel());
        bus_access(REG_CTRL, 1'b1, 32'd0);
        bypass_mode = 1'b0;
        repeat (N_BYPASS) send_rgb(random_pixel());

        check_frames();
        bus_access(REG_FRAMES, 1'b1, 32'd0);
        sof_at_clear = sof_total;
        check_frames();

        while (exp_q.size() != 0) begin
            @(posedge aclk);
            #1;
        end
        $display("Test OK");
        $finish;
    end

endmodule
